//--- src.f
rtl/cnn_pkg.sv
rtl/coef_loader.sv
rtl/line_window.sv
rtl/channel_mac.sv
rtl/scan_ctrl.sv
rtl/conv_layer.sv
verif/conv_layer_props.sv
verif/tb_conv_layer.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_conv_layer -Mdir obj_dir -f src.f
./obj_dir/Vtb_conv_layer

//--- verif/tb_conv_layer.sv
module tb_conv_layer;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PIX = cnn_pkg::IMG_W * cnn_pkg::IMG_H;
	localparam int FRAMES = 4;

	logic clk;
	logic rst;
	logic coef_valid;
	cnn_pkg::word_t coef_data;
	logic pixel_valid;
	cnn_pkg::word_t pixel_data;
	logic coef_loaded;
	logic out_valid;
	cnn_pkg::coord_t out_row;
	cnn_pkg::coord_t out_col;
	cnn_pkg::word_t out_data [cnn_pkg::NUM_CH];
	logic frame_done;

	cnn_pkg::word_t coefs [cnn_pkg::COEF_COUNT];
	cnn_pkg::word_t pix [PIX];
	cnn_pkg::coord_t exp_row [$];
	cnn_pkg::coord_t exp_col [$];
	cnn_pkg::word_t exp_data [$];
	bit exp_last [$];
	int done_count;
	string test_name;

	conv_layer dut0 (.*);

	always #2 clk = ~clk;

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(string what, cnn_pkg::word_t exp, cnn_pkg::word_t act);
		if (exp !== act)
		begin
			$display("Error in %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_coord(string what, cnn_pkg::coord_t exp, cnn_pkg::coord_t act);
		if (exp !== act)
		begin
			$display("Error in %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(string what, bit exp, logic act);
		if (exp !== act)
		begin
			$display("Error in %s, %s: expected %0b, actual %0b", test_name, what, exp, act);
			abort_run();
		end
	endtask

	// expected results of the frame in pix, in raster order
	task automatic predict_frame();
		longint acc;
		for (int r = 0; r < cnn_pkg::OUT_H; r++)
		begin
			for (int c = 0; c < cnn_pkg::OUT_W; c++)
			begin
				exp_row.push_back(cnn_pkg::coord_t'(r));
				exp_col.push_back(cnn_pkg::coord_t'(c));
				exp_last.push_back((r == cnn_pkg::OUT_H - 1) && (c == cnn_pkg::OUT_W - 1));
				for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++)
				begin
					acc = longint'(coefs[cnn_pkg::NUM_CH * cnn_pkg::TAPS + ch])
						<<< cnn_pkg::FRAC_BITS;
					for (int t = 0; t < cnn_pkg::TAPS; t++)
					begin
						acc += longint'(pix[(r + t / cnn_pkg::KERNEL) * cnn_pkg::IMG_W
							+ c + t % cnn_pkg::KERNEL]) * longint'(coefs[ch * cnn_pkg::TAPS + t]);
					end
					exp_data.push_back(cnn_pkg::word_t'(acc >>> cnn_pkg::FRAC_BITS));
				end
			end
		end
	endtask

	task automatic send_frame(bit gaps);
		for (int i = 0; i < PIX; i++)
		begin
			pix[i] = cnn_pkg::word_t'($urandom());
		end
		predict_frame();
		for (int i = 0; i < PIX; i++)
		begin
			while (gaps && (($urandom() % 3) == 0))
			begin
				pixel_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			pixel_valid = 1'b1;
			pixel_data = pix[i];
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		pixel_valid = 1'b0;
		while (exp_row.size() != 0)
		begin
			if (cycles == 100)
			begin
				$display("Timed out in %s with %0d results missing", test_name, exp_row.size());
				abort_run();
			end
			@(posedge clk);
			cycles++;
		end
		#1;
	endtask

	// every out_valid must match the head of the model queue
	always @(negedge clk)
	begin
		if (!rst && out_valid)
		begin
			if (exp_row.size() == 0)
			begin
				$display("Result appeared in %s although none was expected", test_name);
				abort_run();
			end
			check_coord("out_row", exp_row.pop_front(), out_row);
			check_coord("out_col", exp_col.pop_front(), out_col);
			for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++)
			begin
				check_word("out_data", exp_data.pop_front(), out_data[ch]);
			end
			check_flag("frame_done", exp_last.pop_front(), frame_done);
		end
		else if (!rst)
		begin
			check_flag("frame_done without out_valid", 1'b0, frame_done);
		end
		if (!rst && frame_done)
			done_count++;
	end

	initial
	begin
		int accepted;
		void'($urandom(32'hecb4_de85));
		clk = 1'b0;
		rst = 1'b1;
		coef_valid = 1'b0;
		coef_data = '0;
		pixel_valid = 1'b0;
		pixel_data = '0;
		done_count = 0;
		test_name = "reset";
		@(posedge clk);
		#1;
		check_flag("coef_loaded", 1'b0, coef_loaded);
		check_flag("out_valid", 1'b0, out_valid);
		check_flag("frame_done", 1'b0, frame_done);
		@(posedge clk);
		#1;
		rst = 1'b0;

		// pixels offered while loading are dropped
		test_name = "coefficient load";
		accepted = 0;
		while (accepted < cnn_pkg::COEF_COUNT)
		begin
			check_flag("coef_loaded before last word", 1'b0, coef_loaded);
			coefs[accepted] = cnn_pkg::word_t'($urandom());
			coef_valid = ($urandom() % 4) != 0;
			coef_data = coefs[accepted];
			pixel_valid = ($urandom() % 2) != 0;
			pixel_data = cnn_pkg::word_t'($urandom());
			@(posedge clk);
			#1;
			if (coef_valid)
				accepted++;
		end
		coef_valid = 1'b0;
		pixel_valid = 1'b0;
		check_flag("coef_loaded after last word", 1'b1, coef_loaded);
		for (int i = 0; i < 8; i++)
		begin
			coef_valid = 1'b1;
			coef_data = cnn_pkg::word_t'($urandom());
			@(posedge clk);
			#1;
		end
		coef_valid = 1'b0;

		test_name = "back-to-back frame";
		send_frame(1'b0);
		wait_results();
		test_name = "frame with gaps";
		send_frame(1'b1);
		wait_results();
		test_name = "two frames in a row";
		send_frame(1'b0);
		send_frame(1'b1);
		wait_results();

		// any stray result would show up in this quiet period
		repeat (10) @(posedge clk);
		test_name = "frame count";
		if (done_count != FRAMES)
		begin
			$display("Error in %s, frame_done pulses: expected %0d, actual %0d",
				test_name, FRAMES, done_count);
			abort_run();
		end
		else
		begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

//--- verif/conv_layer_props.sv
module conv_layer_props (
	input logic            clk,
	input logic            rst,
	input logic            coef_loaded,
	input logic            out_valid,
	input cnn_pkg::coord_t out_col,
	input logic            frame_done
);
	timeunit 1ns;
	timeprecision 100ps;

	// no result before the coefficients are in
	a_loaded: assert property (@(posedge clk) disable iff (rst)
		(out_valid || frame_done) |-> coef_loaded)
		else $error("result flag raised before coefficients were loaded");

	a_done_valid: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> out_valid)
		else $error("frame_done raised without out_valid");

	a_col_range: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> (int'(out_col) < cnn_pkg::OUT_W))
		else $error("out_col beyond the output width");

	// one pulse per frame
	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		frame_done |=> !frame_done)
		else $error("frame_done high for two cycles");

endmodule

bind conv_layer conv_layer_props props0 (
	.clk(clk),
	.rst(rst),
	.coef_loaded(coef_loaded),
	.out_valid(out_valid),
	.out_col(out_col),
	.frame_done(frame_done)
);

//--- rtl/conv_layer.sv
module conv_layer (
	input  logic           clk,
	input  logic           rst,
	input  logic           coef_valid,
	input  cnn_pkg::word_t coef_data,
	input  logic           pixel_valid,
	input  cnn_pkg::word_t pixel_data,
	output logic           coef_loaded,
	output logic           out_valid,
	output cnn_pkg::coord_t out_row,
	output cnn_pkg::coord_t out_col,
	output cnn_pkg::word_t out_data [cnn_pkg::NUM_CH],
	output logic           frame_done
);

	cnn_pkg::word_t weights [cnn_pkg::NUM_CH][cnn_pkg::TAPS];
	cnn_pkg::word_t biases [cnn_pkg::NUM_CH];
	cnn_pkg::word_t window [cnn_pkg::TAPS];
	logic pixel_take;

	// pixels only count once all coefficients are in place
	assign pixel_take = pixel_valid && coef_loaded;

	coef_loader loader (
		.clk(clk),
		.rst(rst),
		.coef_valid(coef_valid),
		.coef_data(coef_data),
		.coef_loaded(coef_loaded),
		.weights(weights),
		.biases(biases)
	);

	line_window win (
		.clk(clk),
		.rst(rst),
		.pixel_take(pixel_take),
		.pixel_data(pixel_data),
		.window(window)
	);

	scan_ctrl scan (
		.clk(clk),
		.rst(rst),
		.pixel_take(pixel_take),
		.out_valid(out_valid),
		.out_row(out_row),
		.out_col(out_col),
		.frame_done(frame_done)
	);

	for (genvar g = 0; g < cnn_pkg::NUM_CH; g++)
	begin : g_ch
		channel_mac mac (
			.clk(clk),
			.rst(rst),
			.window(window),
			.weights(weights[g]),
			.bias(biases[g]),
			.result(out_data[g])
		);
	end

endmodule

//--- rtl/scan_ctrl.sv
module scan_ctrl (
	input  logic            clk,
	input  logic            rst,
	input  logic            pixel_take,
	output logic            out_valid,
	output cnn_pkg::coord_t out_row,
	output cnn_pkg::coord_t out_col,
	output logic            frame_done
);

	cnn_pkg::scan_state_t state;
	cnn_pkg::coord_t row;
	cnn_pkg::coord_t col;
	logic col_end;
	logic last_px;
	logic mark;

	// first delay stage lines up with the window registers
	logic valid_d1;
	logic done_d1;
	cnn_pkg::coord_t row_d1;
	cnn_pkg::coord_t col_d1;

	assign col_end = (col == cnn_pkg::coord_t'(cnn_pkg::IMG_W - 1));
	assign last_px = col_end && (row == cnn_pkg::coord_t'(cnn_pkg::IMG_H - 1));

	// a full window exists once two lines and two columns are behind us
	assign mark = pixel_take && (state == cnn_pkg::scan_run)
		&& (row >= cnn_pkg::coord_t'(cnn_pkg::KERNEL - 1))
		&& (col >= cnn_pkg::coord_t'(cnn_pkg::KERNEL - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= cnn_pkg::scan_idle;
			row <= '0;
			col <= '0;
		end
		else if (pixel_take)
		begin
			if (last_px)
			begin
				// ready for a back-to-back frame
				state <= cnn_pkg::scan_idle;
				row <= '0;
				col <= '0;
			end
			else
			begin
				state <= cnn_pkg::scan_run;
				if (col_end)
				begin
					col <= '0;
					row <= row + 1'b1;
				end
				else
				begin
					col <= col + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			valid_d1 <= 1'b0;
			done_d1 <= 1'b0;
			out_valid <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			valid_d1 <= mark;
			done_d1 <= mark && last_px;
			out_valid <= valid_d1;
			frame_done <= done_d1;
		end
	end

	// output coordinates are offset by the kernel border
	always_ff @(posedge clk)
	begin
		row_d1 <= row - cnn_pkg::coord_t'(cnn_pkg::KERNEL - 1);
		col_d1 <= col - cnn_pkg::coord_t'(cnn_pkg::KERNEL - 1);
		out_row <= row_d1;
		out_col <= col_d1;
	end

endmodule

//--- rtl/channel_mac.sv
module channel_mac (
	input  logic           clk,
	input  logic           rst,
	input  cnn_pkg::word_t window [cnn_pkg::TAPS],
	input  cnn_pkg::word_t weights [cnn_pkg::TAPS],
	input  cnn_pkg::word_t bias,
	output cnn_pkg::word_t result
);

	cnn_pkg::acc_t prod [cnn_pkg::TAPS];
	cnn_pkg::acc_t lvl1 [5];
	cnn_pkg::acc_t lvl2 [3];
	cnn_pkg::acc_t sum;

	always_comb
	begin
		for (int i = 0; i < cnn_pkg::TAPS; i++)
		begin
			prod[i] = cnn_pkg::acc_t'(window[i]) * cnn_pkg::acc_t'(weights[i]);
		end

		// pairwise tree with the bias riding on the odd product
		for (int i = 0; i < 4; i++)
		begin
			lvl1[i] = prod[2*i] + prod[2*i+1];
		end
		lvl1[4] = prod[8] + (cnn_pkg::acc_t'(bias) <<< cnn_pkg::FRAC_BITS);

		lvl2[0] = lvl1[0] + lvl1[1];
		lvl2[1] = lvl1[2] + lvl1[3];
		lvl2[2] = lvl1[4];

		sum = lvl2[0] + lvl2[1] + lvl2[2];
	end

	// drop the fraction bits and wrap on overflow
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			result <= '0;
		end
		else
		begin
			result <= sum[cnn_pkg::FRAC_BITS +: cnn_pkg::WORD_W];
		end
	end

endmodule

//--- rtl/line_window.sv
module line_window (
	input  logic           clk,
	input  logic           rst,
	input  logic           pixel_take,
	input  cnn_pkg::word_t pixel_data,
	output cnn_pkg::word_t window [cnn_pkg::TAPS]
);

	// slot 0 holds the newest pixel
	cnn_pkg::word_t chain [cnn_pkg::LINE_LEN];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < cnn_pkg::LINE_LEN; i++)
			begin
				chain[i] <= '0;
			end
		end
		else if (pixel_take)
		begin
			chain[0] <= pixel_data;
			for (int i = 1; i < cnn_pkg::LINE_LEN; i++)
			begin
				chain[i] <= chain[i-1];
			end
		end
	end

	// rows of the window are one image line apart in the chain.
	// tap 0 is the oldest pixel (top-left), tap 8 the newest
	always_comb
	begin
		for (int r = 0; r < cnn_pkg::KERNEL; r++)
		begin
			for (int c = 0; c < cnn_pkg::KERNEL; c++)
			begin
				window[r*cnn_pkg::KERNEL+c] =
					chain[(cnn_pkg::KERNEL-1-r)*cnn_pkg::IMG_W + (cnn_pkg::KERNEL-1-c)];
			end
		end
	end

endmodule

//--- rtl/coef_loader.sv
module coef_loader (
	input  logic           clk,
	input  logic           rst,
	input  logic           coef_valid,
	input  cnn_pkg::word_t coef_data,
	output logic           coef_loaded,
	output cnn_pkg::word_t weights [cnn_pkg::NUM_CH][cnn_pkg::TAPS],
	output cnn_pkg::word_t biases [cnn_pkg::NUM_CH]
);

	cnn_pkg::load_state_t state;
	cnn_pkg::load_state_t state_next;
	logic [cnn_pkg::COEF_CNT_W-1:0] count;
	logic take;
	logic last_word;
	cnn_pkg::word_t chain [cnn_pkg::COEF_COUNT];

	assign take = coef_valid && (state != cnn_pkg::load_done);
	assign last_word = take && (int'(count) == cnn_pkg::COEF_COUNT - 1);
	assign coef_loaded = (state == cnn_pkg::load_done);

	always_comb
	begin
		state_next = state;
		case (state)
			cnn_pkg::load_idle:
			begin
				if (take)
				begin
					state_next = cnn_pkg::load_fill;
				end
			end
			cnn_pkg::load_fill:
			begin
				if (last_word)
				begin
					state_next = cnn_pkg::load_done;
				end
			end
			default:
			begin
				state_next = cnn_pkg::load_done;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= cnn_pkg::load_idle;
			count <= '0;
		end
		else
		begin
			state <= state_next;
			if (take)
			begin
				count <= count + 1'b1;
			end
		end
	end

	// new words enter at the top, so word k ends up in slot k
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < cnn_pkg::COEF_COUNT; i++)
			begin
				chain[i] <= '0;
			end
		end
		else if (take)
		begin
			for (int i = 0; i < cnn_pkg::COEF_COUNT - 1; i++)
			begin
				chain[i] <= chain[i+1];
			end
			chain[cnn_pkg::COEF_COUNT-1] <= coef_data;
		end
	end

	// weights sit ahead of the biases in the chain
	always_comb
	begin
		for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++)
		begin
			for (int t = 0; t < cnn_pkg::TAPS; t++)
			begin
				weights[ch][t] = chain[ch*cnn_pkg::TAPS+t];
			end
			biases[ch] = chain[cnn_pkg::NUM_CH*cnn_pkg::TAPS+ch];
		end
	end

endmodule

//--- rtl/cnn_pkg.sv
package cnn_pkg;

	// word and accumulator sizes
	localparam int WORD_W = 16;
	localparam int ACC_W = 40;
	// q7.8 fixed point
	localparam int FRAC_BITS = 8;
	localparam int COORD_W = 4;

	// kernel geometry
	localparam int KERNEL = 3;
	localparam int TAPS = KERNEL * KERNEL;
	localparam int NUM_CH = 4;

	// frame geometry
	localparam int IMG_W = 8;
	localparam int IMG_H = 8;
	localparam int OUT_W = IMG_W - KERNEL + 1;
	localparam int OUT_H = IMG_H - KERNEL + 1;

	// weights for every tap and channel, then one bias per channel
	localparam int COEF_COUNT = NUM_CH * TAPS + NUM_CH;
	localparam int COEF_CNT_W = $clog2(COEF_COUNT + 1);

	// two full lines plus the three newest pixels
	localparam int LINE_LEN = (KERNEL - 1) * IMG_W + KERNEL;

	typedef logic signed [WORD_W-1:0] word_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [COORD_W-1:0] coord_t;

	typedef enum logic [1:0] {
		load_idle,
		load_fill,
		load_done
	} load_state_t;

	typedef enum logic {
		scan_idle,
		scan_run
	} scan_state_t;

endpackage
